/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lvds_tx_io
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
hdl/lvds_cfg_pkg.sv
hdl/lvds_types_pkg.sv
hdl/tx_clock_gen.sv
hdl/tx_frame_buffer.sv
hdl/tx_serializer.sv
hdl/lvds_tx_io.sv
testbench/tb_lvds_checks.sv
testbench/tb_lvds_tx_io.sv

/* hdl/lvds_cfg_pkg.sv */
`default_nettype none

package lvds_cfg_pkg;

   // serialization factor, bits per lane word
   localparam int WORD_BITS = 10;

   // one frame lasts one word on the wire
   localparam int FRAME_PHASES = WORD_BITS;

   // width of the frame phase counter
   localparam int PHASE_BITS = $clog2(FRAME_PHASES);

   // forwarded clock shape, also sent on every lane during training
   localparam logic [WORD_BITS-1:0] TRAIN_WORD = 10'b11111_00000;

   // sent when no frame arrived in time
   // differs from TRAIN_WORD so the receiver never aligns on it
   localparam logic [WORD_BITS-1:0] IDLE_WORD = 10'b00011_11111;

endpackage

`default_nettype wire

/* hdl/lvds_tx_io.sv */
`timescale 1ns/1ps
`default_nettype none

module lvds_tx_io #(
   parameter int LANES       = 60,
   parameter int LOCK_CYCLES = 256
) (
   input  logic                                tx_inclock,
   input  logic                                rst_n,
   input  logic                                pll_areset,
   input  logic                                train,
   input  lvds_types_pkg::tx_word_t [LANES-1:0] frame,
   input  logic                                frame_strobe,
   output logic [LANES-1:0]                    tx_out,
   output logic                                tx_outclock,
   output lvds_types_pkg::tx_status_t          status
);

   import lvds_types_pkg::*;

   logic                 load;
   logic                 locked;
   logic                 underrun;
   tx_word_t [LANES-1:0] load_words;

   tx_clock_gen #(
      .LOCK_CYCLES (LOCK_CYCLES)
   ) u_clock_gen (
      .tx_inclock  (tx_inclock),
      .rst_n       (rst_n),
      .pll_areset  (pll_areset),
      .load        (load),
      .locked      (locked),
      .tx_outclock (tx_outclock)
   );

   tx_frame_buffer #(
      .LANES (LANES)
   ) u_frame_buffer (
      .tx_inclock   (tx_inclock),
      .rst_n        (rst_n),
      .frame        (frame),
      .frame_strobe (frame_strobe),
      .train        (train),
      .load         (load),
      .load_words   (load_words),
      .underrun     (underrun)
   );

   tx_serializer #(
      .LANES (LANES)
   ) u_serializer (
      .tx_inclock (tx_inclock),
      .rst_n      (rst_n),
      .load       (load),
      .load_words (load_words),
      .locked     (locked),
      .tx_out     (tx_out)
   );

   assign status.locked   = locked;
   assign status.training = train;
   assign status.underrun = underrun;

endmodule

`default_nettype wire

/* hdl/lvds_types_pkg.sv */
`default_nettype none

package lvds_types_pkg;

   // one serial lane word, MSB leaves first
   typedef logic [lvds_cfg_pkg::WORD_BITS-1:0] tx_word_t;

   // link status seen from outside
   typedef struct packed {
      logic locked;
      logic training;
      logic underrun;
   } tx_status_t;

endpackage

`default_nettype wire

/* hdl/tx_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_clock_gen #(
   parameter int LOCK_CYCLES = 256
) (
   input  logic tx_inclock,
   input  logic rst_n,
   input  logic pll_areset,
   output logic load,
   output logic locked,
   output logic tx_outclock
);

   import lvds_cfg_pkg::*;

   localparam int CNT_W = $clog2(LOCK_CYCLES + 1);

   logic                  clr;
   logic [CNT_W-1:0]      lock_cnt;
   logic [PHASE_BITS-1:0] phase;
   int                    out_idx;

   assign clr = !rst_n || pll_areset;

   // pll acquisition model, holds once locked
   always_ff @(posedge tx_inclock) begin
      if (clr) begin
         lock_cnt <= '0;
         locked   <= 1'b0;
      end else if (!locked) begin
         lock_cnt <= lock_cnt + 1'b1;
         if (lock_cnt == CNT_W'(LOCK_CYCLES - 1)) begin
            locked <= 1'b1;
         end
      end
   end

   // frame phase, idle at zero until lock
   always_ff @(posedge tx_inclock) begin
      if (clr || !locked) begin
         phase <= '0;
      end else if (phase == PHASE_BITS'(FRAME_PHASES - 1)) begin
         phase <= '0;
      end else begin
         phase <= phase + 1'b1;
      end
   end

   // one strobe per frame, first one the cycle after lock
   always_ff @(posedge tx_inclock) begin
      if (clr) begin
         load <= 1'b0;
      end else begin
         load <= locked && (phase == '0);
      end
   end

   // load sits at phase 1, so phase p drives bit WORD_BITS-p next cycle
   assign out_idx = (phase == '0) ? 0 : FRAME_PHASES - int'(phase);

   always_ff @(posedge tx_inclock) begin
      if (clr) begin
         tx_outclock <= 1'b0;
      end else begin
         tx_outclock <= locked && TRAIN_WORD[out_idx];
      end
   end

   a_load_locked : assert property (
      @(posedge tx_inclock) disable iff (!rst_n)
      load |-> locked
   ) else $error("load strobe while unlocked");

   a_load_period : assert property (
      @(posedge tx_inclock) disable iff (!rst_n || pll_areset)
      load |=> !load [*FRAME_PHASES-1] ##1 load
   ) else $error("load strobes not %0d cycles apart", FRAME_PHASES);

endmodule

`default_nettype wire

/* hdl/tx_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_buffer #(
   parameter int LANES = 60
) (
   input  logic                                tx_inclock,
   input  logic                                rst_n,
   input  lvds_types_pkg::tx_word_t [LANES-1:0] frame,
   input  logic                                frame_strobe,
   input  logic                                train,
   input  logic                                load,
   output lvds_types_pkg::tx_word_t [LANES-1:0] load_words,
   output logic                                underrun
);

   import lvds_cfg_pkg::*;
   import lvds_types_pkg::*;

   tx_word_t [LANES-1:0] frame_q;
   logic                 pending;

   // latest strobed frame wins
   always_ff @(posedge tx_inclock) begin
      if (frame_strobe) begin
         frame_q <= frame;
      end
   end

   // a strobe together with load belongs to the next frame
   always_ff @(posedge tx_inclock) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (frame_strobe) begin
         pending <= 1'b1;
      end else if (load) begin
         pending <= 1'b0;
      end
   end

   // training beats data and data beats idle
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         if (train) begin
            load_words[i] = TRAIN_WORD;
         end else if (pending) begin
            load_words[i] = frame_q[i];
         end else begin
            load_words[i] = IDLE_WORD;
         end
      end
   end

   assign underrun = load && !train && !pending;

   // underrun lasts a single cycle like the load it comes with
   a_underrun_pulse : assert property (
      @(posedge tx_inclock) disable iff (!rst_n)
      underrun |=> !underrun
   ) else $error("underrun pulse longer than one cycle");

endmodule

`default_nettype wire

/* hdl/tx_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_serializer #(
   parameter int LANES = 60
) (
   input  logic                                tx_inclock,
   input  logic                                rst_n,
   input  logic                                load,
   input  lvds_types_pkg::tx_word_t [LANES-1:0] load_words,
   input  logic                                locked,
   output logic [LANES-1:0]                    tx_out
);

   import lvds_cfg_pkg::*;
   import lvds_types_pkg::*;

   tx_word_t [LANES-1:0] shreg;

   // capture on load, otherwise shift toward the MSB
   always_ff @(posedge tx_inclock) begin
      if (!rst_n || !locked) begin
         shreg <= '0;
      end else begin
         for (int i = 0; i < LANES; i++) begin
            if (load) begin
               shreg[i] <= load_words[i];
            end else begin
               shreg[i] <= {shreg[i][WORD_BITS-2:0], 1'b0};
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         tx_out[i] = locked && shreg[i][WORD_BITS-1];
      end
   end

   // registers are flushed while unlocked, so lanes start quiet after lock
   a_quiet_unlocked : assert property (
      @(posedge tx_inclock) disable iff (!rst_n)
      !locked |=> tx_out == '0
   ) else $error("tx_out active around an unlocked cycle");

endmodule

`default_nettype wire

/* testbench/tb_lvds_checks.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lvds_checks #(
   parameter int LANES = 8
) (
   input  logic                       tx_inclock,
   input  logic                       rst_n,
   input  logic                       pll_areset,
   input  logic                       train,
   input  logic [LANES-1:0]           tx_out,
   input  logic                       tx_outclock,
   input  lvds_types_pkg::tx_status_t status,
   output int                         errors
);

   int quiet_errs = 0;
   int reset_errs = 0;
   int flag_errs  = 0;
   int drop_errs  = 0;
   int under_errs = 0;

   assign errors = quiet_errs + reset_errs + flag_errs + drop_errs + under_errs;

   // every output held at zero in reset
   a_reset_quiet : assert property (
      @(negedge tx_inclock)
      !rst_n |-> (status == '0 && tx_out == '0 && !tx_outclock)
   ) else begin
      reset_errs++;
      $display("mismatch at %0t: outputs not zero during reset", $time);
   end

   a_quiet_unlocked : assert property (
      @(negedge tx_inclock) disable iff (!rst_n)
      !status.locked |-> (tx_out == '0 && !tx_outclock)
   ) else begin
      quiet_errs++;
      $display("mismatch at %0t: lanes active while unlocked", $time);
   end

   a_training_flag : assert property (
      @(negedge tx_inclock) disable iff (!rst_n)
      status.training == train
   ) else begin
      flag_errs++;
      $display("mismatch at %0t: status.training differs from train", $time);
   end

   // lock is gone one edge after the areset request
   a_areset_drop : assert property (
      @(posedge tx_inclock) disable iff (!rst_n)
      pll_areset |=> !status.locked
   ) else begin
      drop_errs++;
      $display("mismatch at %0t: locked still high after pll_areset", $time);
   end

   a_underrun_state : assert property (
      @(negedge tx_inclock) disable iff (!rst_n)
      status.underrun |-> (status.locked && !status.training)
   ) else begin
      under_errs++;
      $display("mismatch at %0t: underrun while unlocked or training", $time);
   end

endmodule

`default_nettype wire

/* testbench/tb_lvds_tx_io.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lvds_tx_io;

   import lvds_cfg_pkg::*;
   import lvds_types_pkg::*;

   localparam int LANES       = 8;
   localparam int LOCK_CYCLES = 40;

   logic                 tx_inclock;
   logic                 rst_n        = 1'b0;
   logic                 pll_areset   = 1'b0;
   logic                 train        = 1'b0;
   tx_word_t [LANES-1:0] frame        = '0;
   logic                 frame_strobe = 1'b0;
   logic [LANES-1:0]     tx_out;
   logic                 tx_outclock;
   tx_status_t           status;
   int                   chk_errors;

   // requests from the sequence to the negedge driver
   logic run_data    = 1'b0;
   logic train_req   = 1'b0;
   int   skip_reqs   = 0;
   int   areset_reqs = 0;

   // driver and reference model state
   int                   cyc         = 0;
   int                   skips_done  = 0;
   int                   areset_done = 0;
   int                   areset_left = 0;
   logic [31:0]          rng         = 32'd52;
   logic                 pending_m   = 1'b0;
   tx_word_t [LANES-1:0] frame_m     = '0;
   logic                 strobe_prev = 1'b0;
   tx_word_t [LANES-1:0] exp_prev    = '0;
   logic                 exp_under_prev = 1'b0;
   logic                 under_seen_prev = 1'b0;
   logic                 clk_prev    = 1'b0;

   // deserializer state
   int                   bit_idx     = -1;
   int                   last_rise   = -1;
   tx_word_t [LANES-1:0] got         = '0;
   tx_word_t [LANES-1:0] exp_word    = '0;
   tx_word_t             clk_word    = '0;

   int words_done  = 0;
   int data_words  = 0;
   int train_words = 0;
   int idle_words  = 0;
   int tb_errors   = 0;

   lvds_tx_io #(
      .LANES       (LANES),
      .LOCK_CYCLES (LOCK_CYCLES)
   ) dut0 (
      .tx_inclock   (tx_inclock),
      .rst_n        (rst_n),
      .pll_areset   (pll_areset),
      .train        (train),
      .frame        (frame),
      .frame_strobe (frame_strobe),
      .tx_out       (tx_out),
      .tx_outclock  (tx_outclock),
      .status       (status)
   );

   tb_lvds_checks #(
      .LANES (LANES)
   ) chk0 (
      .tx_inclock  (tx_inclock),
      .rst_n       (rst_n),
      .pll_areset  (pll_areset),
      .train       (train),
      .tx_out      (tx_out),
      .tx_outclock (tx_outclock),
      .status      (status),
      .errors      (chk_errors)
   );

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   initial begin
      tx_inclock = 1'b0;
      forever #50 tx_inclock = ~tx_inclock;
   end

   // sample outputs first, then drive the inputs for this cycle
   always @(negedge tx_inclock) begin
      logic rise;
      logic all_train;
      logic all_idle;
      rise = status.locked && tx_outclock && !clk_prev;
      if (!status.locked) begin
         bit_idx   = -1;
         last_rise = -1;
      end else if (rise) begin
         assert (last_rise < 0 || cyc - last_rise == FRAME_PHASES) else begin
            tb_errors++;
            $display("mismatch at %0t: frame boundary after %0d cycles", $time,
                     cyc - last_rise);
         end
         last_rise = cyc;
         // the load last cycle consumed the frame unless a strobe came with it
         if (!strobe_prev) begin
            pending_m = 1'b0;
         end
         exp_word = exp_prev;
         bit_idx  = 0;
      end
      assert (under_seen_prev == (rise && exp_under_prev)) else begin
         tb_errors++;
         $display("mismatch at %0t: underrun %0b expected %0b", $time,
                  under_seen_prev, rise && exp_under_prev);
      end
      if (bit_idx >= 0) begin
         for (int i = 0; i < LANES; i++) begin
            got[i] = {got[i][WORD_BITS-2:0], tx_out[i]};
         end
         clk_word = {clk_word[WORD_BITS-2:0], tx_outclock};
         bit_idx++;
         if (bit_idx == WORD_BITS) begin
            assert (clk_word == TRAIN_WORD) else begin
               tb_errors++;
               $display("mismatch at %0t: clock lane %b", $time, clk_word);
            end
            all_train = 1'b1;
            all_idle  = 1'b1;
            for (int i = 0; i < LANES; i++) begin
               assert (got[i] == exp_word[i]) else begin
                  tb_errors++;
                  $display("mismatch at %0t: lane %0d got %b expected %b", $time, i,
                           got[i], exp_word[i]);
               end
               all_train = all_train && (exp_word[i] == TRAIN_WORD);
               all_idle  = all_idle && (exp_word[i] == IDLE_WORD);
            end
            if (all_train) begin
               train_words++;
            end else if (all_idle) begin
               idle_words++;
            end else begin
               data_words++;
            end
            words_done++;
            bit_idx = -1;
         end
      end
      clk_prev = tx_outclock;

      rst_n = (cyc >= 10);
      if (areset_done < areset_reqs) begin
         areset_done++;
         areset_left = 3;
      end
      pll_areset = (areset_left > 0);
      if (areset_left > 0) begin
         areset_left--;
      end
      train        = train_req;
      frame_strobe = 1'b0;
      if (run_data && cyc % FRAME_PHASES == 3) begin
         if (skips_done < skip_reqs) begin
            skips_done++;
         end else begin
            frame_strobe = 1'b1;
            for (int i = 0; i < LANES; i++) begin
               rng      = next_random(rng);
               frame[i] = tx_word_t'(rng);
            end
         end
      end

      // word the DUT would pick if this cycle were a load
      exp_under_prev = !train && !pending_m;
      for (int i = 0; i < LANES; i++) begin
         exp_prev[i] = train ? TRAIN_WORD : (pending_m ? frame_m[i] : IDLE_WORD);
      end
      if (frame_strobe) begin
         pending_m = 1'b1;
         frame_m   = frame;
      end
      strobe_prev = frame_strobe;
      #1;
      under_seen_prev = status.underrun;
      cyc++;
   end

   task automatic wait_locked(input logic level, input int limit, output logic ok);
      int n;
      n = 0;
      while (status.locked != level && n < limit) begin
         @(posedge tx_inclock);
         n++;
      end
      ok = (status.locked == level);
      if (!ok) begin
         $display("timeout: locked did not become %0b within %0d cycles", level, limit);
      end
   endtask

   task automatic wait_words(input int count, input int limit, output logic ok);
      int n;
      int target;
      n      = 0;
      target = words_done + count;
      while (words_done < target && n < limit) begin
         @(posedge tx_inclock);
         n++;
      end
      ok = (words_done >= target);
      if (!ok) begin
         $display("timeout: only %0d of %0d words arrived", count - (target - words_done),
                  count);
      end
   endtask

   task automatic run_sequence(output logic ok);
      int n;
      n = 0;
      while (!rst_n && n < 20) begin
         @(posedge tx_inclock);
         n++;
      end
      ok = rst_n;
      if (!ok) begin
         $display("timeout: reset was never released");
         return;
      end
      assert (tx_out == '0 && !tx_outclock && status == '0) else begin
         tb_errors++;
         $display("mismatch at %0t: outputs not zero after reset", $time);
      end
      wait_locked(1'b1, LOCK_CYCLES + 2, ok);
      if (!ok) return;
      run_data = 1'b1;
      wait_words(8, 200, ok);
      if (!ok) return;
      // one missing frame gives one idle word
      skip_reqs++;
      wait_words(4, 100, ok);
      if (!ok) return;
      train_req = 1'b1;
      // a missing frame during training still sends the training word
      skip_reqs++;
      wait_words(4, 100, ok);
      if (!ok) return;
      train_req = 1'b0;
      wait_words(3, 100, ok);
      if (!ok) return;
      areset_reqs++;
      wait_locked(1'b0, 10, ok);
      if (!ok) return;
      wait_locked(1'b1, LOCK_CYCLES + 10, ok);
      if (!ok) return;
      wait_words(5, 100, ok);
   endtask

   initial begin
      logic ok;
      run_sequence(ok);
      if (ok && (data_words == 0 || train_words == 0 || idle_words == 0)) begin
         tb_errors++;
         $display("not every word kind was seen: data %0d training %0d idle %0d",
                  data_words, train_words, idle_words);
      end
      $display("errors: %0d checker, %0d testbench; words checked %0d", chk_errors,
               tb_errors, words_done);
      if (ok && chk_errors == 0 && tb_errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
